/* Makefile */
# Verilator build and run of the testbench
VERILATOR ?= verilator
TOP       ?= tb_ara_lite
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* dv/vec_ref_model.svh */
`ifndef VEC_REF_MODEL_SVH
`define VEC_REF_MODEL_SVH

// Mirror of the vector register file with one row per register
logic [ELEM_W-1:0] model_vrf [NR_VREGS][NR_LANES];

function automatic void clear_model_regs();
  for (int r = 0; r < NR_VREGS; r++) begin
    for (int l = 0; l < NR_LANES; l++) begin
      model_vrf[r][l] = '0;
    end
  end
endfunction

// Applies one instruction to the mirror and returns its scalar result
function automatic logic [ELEM_W-1:0] predict_result(
  input vop_e              op,
  input logic [VREG_W-1:0] vd,
  input logic [VREG_W-1:0] vs1,
  input logic [VREG_W-1:0] vs2,
  input logic [ELEM_W-1:0] scalar
);
  logic [ELEM_W-1:0] a;
  logic [ELEM_W-1:0] b;
  logic [ELEM_W-1:0] sum;
  logic [ELEM_W-1:0] lanes [NR_LANES];
  sum = '0;
  for (int l = 0; l < NR_LANES; l++) begin
    a   = model_vrf[vs1][l];
    b   = model_vrf[vs2][l];
    sum = sum + a;
    case (op)
      VMV_SX:  lanes[l] = scalar;
      VADD:    lanes[l] = a + b;
      VSUB:    lanes[l] = a - b;
      VAND:    lanes[l] = a & b;
      VXOR:    lanes[l] = a ^ b;
      default: lanes[l] = '0;
    endcase
  end
  // Reduction leaves vd untouched
  if (op == VREDSUM) begin
    return sum;
  end
  if (op inside {VMV_SX, VADD, VSUB, VAND, VXOR}) begin
    for (int l = 0; l < NR_LANES; l++) begin
      model_vrf[vd][l] = lanes[l];
    end
  end
  return '0;
endfunction

`endif

/* dv/tb_ara_lite.sv */
module tb_ara_lite import ara_lite_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // Instructions issued by each test
  localparam int TOTAL_INSNS    = 8 + 6 + 20 + 10 + 12 + 30;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_INSNS + 200;

  logic              clk_i = 1'b0;
  logic              rst_i;
  logic              issue_valid_i;
  logic              issue_ready_o;
  vop_e              issue_op_i;
  logic [VREG_W-1:0] issue_vd_i;
  logic [VREG_W-1:0] issue_vs1_i;
  logic [VREG_W-1:0] issue_vs2_i;
  logic [ELEM_W-1:0] issue_scalar_i;
  logic              resp_valid_o;
  logic              resp_ready_i;
  logic [TAG_W-1:0]  resp_tag_o;
  logic [ELEM_W-1:0] resp_result_o;

  int                seed = 48;
  int                err_cnt = 0;
  int                err_at_start = 0;
  int                pass_cnt = 0;
  int                fail_cnt = 0;
  int                cycle_cnt = 0;
  int                accepted_cnt = 0;
  int                taken_cnt = 0;
  logic              toggle_ready = 1'b0;
  logic              burst_done = 1'b0;
  logic [TAG_W-1:0]  next_tag = '0;
  logic [TAG_W-1:0]  exp_tag_q [$];
  logic [ELEM_W-1:0] exp_res_q [$];
  logic [TAG_W-1:0]  want_tag;
  logic [ELEM_W-1:0] want_res;

  `include "vec_ref_model.svh"

  ara_lite_system dut (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // Random back-pressure on the response port
  always @(posedge clk_i) begin
    if (toggle_ready) begin
      #2;
      resp_ready_i = ($random(seed) & 32'd1) != 0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Monitors sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (issue_valid_i && issue_ready_o) begin
      accepted_cnt++;
    end
  end

  always @(negedge clk_i) begin
    if (resp_valid_o && resp_ready_i) begin
      taken_cnt++;
      if (exp_tag_q.size() == 0) begin
        err_cnt++;
        $display("error at %0t: response with tag %0d while none outstanding",
                 $time, resp_tag_o);
      end else begin
        want_tag = exp_tag_q.pop_front();
        want_res = exp_res_q.pop_front();
        if (resp_tag_o !== want_tag) begin
          err_cnt++;
          $display("error at %0t: tag %0d, expected %0d", $time, resp_tag_o, want_tag);
        end
        if (resp_result_o !== want_res) begin
          err_cnt++;
          $display("error at %0t: result %0h for tag %0d, expected %0h",
                   $time, resp_result_o, want_tag, want_res);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Driver tasks
  ////////////////////////////////////////////////////////////

  // Entered and left 2 ns after a rising edge
  task automatic send_insn(input vop_e op, input logic [VREG_W-1:0] vd,
                           input logic [VREG_W-1:0] vs1, input logic [VREG_W-1:0] vs2,
                           input logic [ELEM_W-1:0] scalar);
    issue_valid_i  = 1'b1;
    issue_op_i     = op;
    issue_vd_i     = vd;
    issue_vs1_i    = vs1;
    issue_vs2_i    = vs2;
    issue_scalar_i = scalar;
    do @(negedge clk_i); while (!issue_ready_o);
    exp_tag_q.push_back(next_tag);
    exp_res_q.push_back(predict_result(op, vd, vs1, vs2, scalar));
    next_tag = next_tag + 1'b1;
    @(posedge clk_i);
    #2;
    issue_valid_i = 1'b0;
  endtask

  task automatic drain_responses();
    resp_ready_i = 1'b1;
    while (exp_tag_q.size() != 0) @(negedge clk_i);
    // Quiet window that catches any response beyond the expected ones
    repeat (QUEUE_DEPTH + 4) @(posedge clk_i);
    #2;
  endtask

  task automatic start_test();
    err_at_start = err_cnt;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == err_at_start) begin
      pass_cnt++;
      $display("%s: passed", name);
    end else begin
      fail_cnt++;
      $display("%s: %0d errors", name, err_cnt - err_at_start);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic redsum_after_reset();
    start_test();
    for (int r = 0; r < NR_VREGS; r++) begin
      send_insn(VREDSUM, '0, VREG_W'(r), '0, '0);
    end
    drain_responses();
    end_test("reset state");
  endtask

  task automatic broadcast_sum();
    start_test();
    for (int i = 0; i < 3; i++) begin
      send_insn(VMV_SX, VREG_W'(i), '0, '0, ELEM_W'($random(seed)));
      send_insn(VREDSUM, '0, VREG_W'(i), '0, '0);
    end
    drain_responses();
    end_test("broadcast sum");
  endtask

  task automatic lane_ops();
    vop_e ops [4];
    ops = '{VADD, VSUB, VAND, VXOR};
    start_test();
    for (int round = 0; round < 2; round++) begin
      send_insn(VMV_SX, 3'd1, '0, '0, ELEM_W'($random(seed)));
      send_insn(VMV_SX, 3'd2, '0, '0, ELEM_W'($random(seed)));
      for (int k = 0; k < 4; k++) begin
        send_insn(ops[k], VREG_W'(3 + k), 3'd1, 3'd2, '0);
        send_insn(VREDSUM, '0, VREG_W'(3 + k), '0, '0);
      end
    end
    drain_responses();
    end_test("lane ops");
  endtask

  task automatic tag_order();
    start_test();
    for (int i = 0; i < 10; i++) begin
      send_insn(VMV_SX, VREG_W'(i), '0, '0, ELEM_W'(i));
    end
    drain_responses();
    end_test("tag order");
  endtask

  task automatic held_response_burst();
    int base_acc;
    int base_taken;
    start_test();
    resp_ready_i = 1'b0;
    base_acc     = accepted_cnt;
    base_taken   = taken_cnt;
    burst_done   = 1'b0;
    fork
      begin
        for (int i = 0; i < 12; i++) begin
          send_insn(i[0] ? VREDSUM : VMV_SX, VREG_W'(i / 2), VREG_W'(i / 2), '0,
                    ELEM_W'($random(seed)));
        end
        burst_done = 1'b1;
      end
    join_none
    // Wait for the intake to close and stay closed
    do @(negedge clk_i); while (issue_ready_o);
    repeat (20) @(negedge clk_i);
    if (accepted_cnt - base_acc > MAX_OUTSTANDING) begin
      err_cnt++;
      $display("error at %0t: %0d accepted while responses held, limit %0d",
               $time, accepted_cnt - base_acc, MAX_OUTSTANDING);
    end
    if (resp_valid_o !== 1'b1) begin
      err_cnt++;
      $display("no response was held at the port while resp_ready_i was low");
    end
    @(posedge clk_i);
    #2;
    resp_ready_i = 1'b1;
    wait (burst_done);
    drain_responses();
    if (taken_cnt - base_taken != 12) begin
      err_cnt++;
      $display("error at %0t: %0d responses after the burst, expected 12",
               $time, taken_cnt - base_taken);
    end
    end_test("backpressure");
  endtask

  task automatic random_ready_burst();
    int base_taken;
    int r;
    start_test();
    base_taken   = taken_cnt;
    toggle_ready = 1'b1;
    for (int i = 0; i < 30; i++) begin
      r = $unsigned($random(seed)) % 6;
      send_insn(vop_e'(r[2:0]), VREG_W'($random(seed)), VREG_W'($random(seed)),
                VREG_W'($random(seed)), ELEM_W'($random(seed)));
    end
    toggle_ready = 1'b0;
    @(posedge clk_i);
    #2;
    drain_responses();
    if (taken_cnt - base_taken != 30) begin
      err_cnt++;
      $display("error at %0t: %0d responses, expected 30", $time, taken_cnt - base_taken);
    end
    end_test("random ready");
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    rst_i          = 1'b1;
    issue_valid_i  = 1'b0;
    issue_op_i     = VMV_SX;
    issue_vd_i     = '0;
    issue_vs1_i    = '0;
    issue_vs2_i    = '0;
    issue_scalar_i = '0;
    resp_ready_i   = 1'b1;
    clear_model_regs();
    repeat (8) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    redsum_after_reset();
    broadcast_sum();
    lane_ops();
    tag_order();
    held_response_burst();
    random_ready_burst();

    $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tb_ara_lite

/* hdl/acc_dispatcher.sv */
module acc_dispatcher import ara_lite_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  // Instruction intake
  input  logic              issue_valid_i,
  output logic              issue_ready_o,
  input  vop_e              issue_op_i,
  input  logic [VREG_W-1:0] issue_vd_i,
  input  logic [VREG_W-1:0] issue_vs1_i,
  input  logic [VREG_W-1:0] issue_vs2_i,
  input  logic [ELEM_W-1:0] issue_scalar_i,
  // Towards the accelerator
  acc_req_if.producer       issue_o,
  acc_resp_if.consumer      resp_i,
  // Retired responses
  output logic              resp_valid_o,
  input  logic              resp_ready_i,
  output logic [TAG_W-1:0]  resp_tag_o,
  output logic [ELEM_W-1:0] resp_result_o
);

  logic               out_valid_q;
  logic               out_stall;
  logic               issue_fire;
  logic               resp_fire;
  logic [TAG_W-1:0]   tag_q;
  logic [OUTST_W-1:0] outst_q;

  assign out_stall     = out_valid_q && !issue_o.ready;
  assign issue_ready_o = !out_stall && (outst_q != OUTST_W'(MAX_OUTSTANDING));
  assign issue_fire    = issue_valid_i && issue_ready_o;
  assign resp_fire     = resp_valid_o && resp_ready_i;

  ////////////////////////////////////////////////////////////
  // Issue register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q <= 1'b0;
      tag_q       <= '0;
    end else if (issue_fire) begin
      out_valid_q <= 1'b1;
      tag_q       <= tag_q + 1'b1;
    end else if (issue_o.ready) begin
      out_valid_q <= 1'b0;
    end
  end

  // Payload follows the valid bit
  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      issue_o.op     <= issue_op_i;
      issue_o.vd     <= issue_vd_i;
      issue_o.vs1    <= issue_vs1_i;
      issue_o.vs2    <= issue_vs2_i;
      issue_o.scalar <= issue_scalar_i;
      issue_o.tag    <= tag_q;
    end
  end

  assign issue_o.valid = out_valid_q;

  // Instructions in flight until their response is taken
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outst_q <= '0;
    end else begin
      case ({issue_fire, resp_fire})
        2'b10:   outst_q <= outst_q + 1'b1;
        2'b01:   outst_q <= outst_q - 1'b1;
        default: outst_q <= outst_q;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Response return
  ////////////////////////////////////////////////////////////

  assign resp_valid_o  = resp_i.valid;
  assign resp_tag_o    = resp_i.tag;
  assign resp_result_o = resp_i.result;
  assign resp_i.ready  = resp_ready_i;

endmodule : acc_dispatcher

/* hdl/acc_insn_queue.sv */
module acc_insn_queue import ara_lite_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  acc_req_if.consumer push_i,
  acc_req_if.producer pop_o
);

  vop_e              op_mem     [QUEUE_DEPTH];
  logic [VREG_W-1:0] vd_mem     [QUEUE_DEPTH];
  logic [VREG_W-1:0] vs1_mem    [QUEUE_DEPTH];
  logic [VREG_W-1:0] vs2_mem    [QUEUE_DEPTH];
  logic [ELEM_W-1:0] scalar_mem [QUEUE_DEPTH];
  logic [TAG_W-1:0]  tag_mem    [QUEUE_DEPTH];

  logic [QPTR_W-1:0] wr_ptr_q;
  logic [QPTR_W-1:0] rd_ptr_q;
  logic [QCNT_W-1:0] count_q;
  logic              push_fire;
  logic              pop_fire;

  function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] ptr);
    if (ptr == QPTR_W'(QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign pop_o.valid  = (count_q != '0);
  assign pop_fire     = pop_o.valid && pop_o.ready;
  // Full queue still takes a push when the head leaves
  assign push_i.ready = (count_q != QCNT_W'(QUEUE_DEPTH)) || pop_fire;
  assign push_fire    = push_i.valid && push_i.ready;

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      op_mem[wr_ptr_q]     <= push_i.op;
      vd_mem[wr_ptr_q]     <= push_i.vd;
      vs1_mem[wr_ptr_q]    <= push_i.vs1;
      vs2_mem[wr_ptr_q]    <= push_i.vs2;
      scalar_mem[wr_ptr_q] <= push_i.scalar;
      tag_mem[wr_ptr_q]    <= push_i.tag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_fire) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_fire)  rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign pop_o.op     = op_mem[rd_ptr_q];
  assign pop_o.vd     = vd_mem[rd_ptr_q];
  assign pop_o.vs1    = vs1_mem[rd_ptr_q];
  assign pop_o.vs2    = vs2_mem[rd_ptr_q];
  assign pop_o.scalar = scalar_mem[rd_ptr_q];
  assign pop_o.tag    = tag_mem[rd_ptr_q];

endmodule : acc_insn_queue

/* hdl/acc_req_if.sv */
interface acc_req_if import ara_lite_pkg::*; ();

  logic              valid;
  logic              ready;
  vop_e              op;
  logic [VREG_W-1:0] vd;
  logic [VREG_W-1:0] vs1;
  logic [VREG_W-1:0] vs2;
  logic [ELEM_W-1:0] scalar;
  logic [TAG_W-1:0]  tag;

  // Issuing side
  modport producer (
    output valid, op, vd, vs1, vs2, scalar, tag,
    input  ready
  );

  // Accepting side
  modport consumer (
    input  valid, op, vd, vs1, vs2, scalar, tag,
    output ready
  );

endinterface : acc_req_if

/* hdl/acc_resp_if.sv */
interface acc_resp_if import ara_lite_pkg::*; ();

  logic              valid;
  logic              ready;
  logic [TAG_W-1:0]  tag;
  logic [ELEM_W-1:0] result;

  modport producer (
    output valid, tag, result,
    input  ready
  );

  modport consumer (
    input  valid, tag, result,
    output ready
  );

endinterface : acc_resp_if

/* hdl/ara_lite_pkg.sv */
package ara_lite_pkg;

  ////////////////////////////////////////////////////////////
  // Sizing
  ////////////////////////////////////////////////////////////

  localparam int unsigned NR_LANES  = 4;
  localparam int unsigned ELEM_W    = 16;
  localparam int unsigned NR_VREGS  = 8;
  localparam int unsigned VREG_W    = $clog2(NR_VREGS);

  // Tag space bounds the number of instructions in flight
  localparam int unsigned TAG_W           = 3;
  localparam int unsigned MAX_OUTSTANDING = 2 ** TAG_W;
  localparam int unsigned OUTST_W         = $clog2(MAX_OUTSTANDING + 1);

  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int unsigned QCNT_W      = $clog2(QUEUE_DEPTH + 1);

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    VMV_SX  = 3'd0,
    VADD    = 3'd1,
    VSUB    = 3'd2,
    VAND    = 3'd3,
    VXOR    = 3'd4,
    VREDSUM = 3'd5
  } vop_e;

endpackage : ara_lite_pkg

/* hdl/ara_lite_system.sv */
module ara_lite_system import ara_lite_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  // Instruction issue
  input  logic              issue_valid_i,
  output logic              issue_ready_o,
  input  vop_e              issue_op_i,
  input  logic [VREG_W-1:0] issue_vd_i,
  input  logic [VREG_W-1:0] issue_vs1_i,
  input  logic [VREG_W-1:0] issue_vs2_i,
  input  logic [ELEM_W-1:0] issue_scalar_i,
  // Responses
  output logic              resp_valid_o,
  input  logic              resp_ready_i,
  output logic [TAG_W-1:0]  resp_tag_o,
  output logic [ELEM_W-1:0] resp_result_o
);

  acc_req_if  issue_bus ();
  acc_req_if  exec_bus  ();
  acc_resp_if resp_bus  ();

  acc_dispatcher i_acc_dispatcher (
    .clk_i          (clk_i         ),
    .rst_i          (rst_i         ),
    .issue_valid_i  (issue_valid_i ),
    .issue_ready_o  (issue_ready_o ),
    .issue_op_i     (issue_op_i    ),
    .issue_vd_i     (issue_vd_i    ),
    .issue_vs1_i    (issue_vs1_i   ),
    .issue_vs2_i    (issue_vs2_i   ),
    .issue_scalar_i (issue_scalar_i),
    .issue_o        (issue_bus     ),
    .resp_i         (resp_bus      ),
    .resp_valid_o   (resp_valid_o  ),
    .resp_ready_i   (resp_ready_i  ),
    .resp_tag_o     (resp_tag_o    ),
    .resp_result_o  (resp_result_o )
  );

  acc_insn_queue i_acc_insn_queue (
    .clk_i  (clk_i    ),
    .rst_i  (rst_i    ),
    .push_i (issue_bus),
    .pop_o  (exec_bus )
  );

  vec_unit i_vec_unit (
    .clk_i  (clk_i   ),
    .rst_i  (rst_i   ),
    .req_i  (exec_bus),
    .resp_o (resp_bus)
  );

endmodule : ara_lite_system

/* hdl/vec_unit.sv */
module vec_unit import ara_lite_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  acc_req_if.consumer  req_i,
  acc_resp_if.producer resp_o
);

  ////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////

  // One row per vector register, one column per lane
  logic [ELEM_W-1:0] vrf [NR_VREGS][NR_LANES];

  logic              req_fire;
  logic              vd_we;
  logic [ELEM_W-1:0] lane_res [NR_LANES];
  logic [ELEM_W-1:0] red_sum;

  logic              resp_valid_q;
  logic [TAG_W-1:0]  resp_tag_q;
  logic [ELEM_W-1:0] resp_result_q;

  // Accept when the response slot is free or draining
  assign req_i.ready = !resp_valid_q || resp_o.ready;
  assign req_fire    = req_i.valid && req_i.ready;

  ////////////////////////////////////////////////////////////
  // Lane execution
  ////////////////////////////////////////////////////////////

  always_comb begin
    red_sum = '0;
    for (int l = 0; l < NR_LANES; l++) begin
      red_sum     = red_sum + vrf[req_i.vs1][l];
      lane_res[l] = '0;
      case (req_i.op)
        VMV_SX:  lane_res[l] = req_i.scalar;
        VADD:    lane_res[l] = vrf[req_i.vs1][l] + vrf[req_i.vs2][l];
        VSUB:    lane_res[l] = vrf[req_i.vs1][l] - vrf[req_i.vs2][l];
        VAND:    lane_res[l] = vrf[req_i.vs1][l] & vrf[req_i.vs2][l];
        VXOR:    lane_res[l] = vrf[req_i.vs1][l] ^ vrf[req_i.vs2][l];
        default: lane_res[l] = '0;
      endcase
    end
  end

  // Only element-wise ops write back
  always_comb begin
    case (req_i.op)
      VMV_SX, VADD, VSUB, VAND, VXOR: vd_we = 1'b1;
      default:                        vd_we = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int r = 0; r < NR_VREGS; r++) begin
        for (int l = 0; l < NR_LANES; l++) begin
          vrf[r][l] <= '0;
        end
      end
    end else if (req_fire && vd_we) begin
      for (int l = 0; l < NR_LANES; l++) begin
        vrf[req_i.vd][l] <= lane_res[l];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_o.ready) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_tag_q    <= req_i.tag;
      // Scalar result only from the reduction
      resp_result_q <= (req_i.op == VREDSUM) ? red_sum : '0;
    end
  end

  assign resp_o.valid  = resp_valid_q;
  assign resp_o.tag    = resp_tag_q;
  assign resp_o.result = resp_result_q;

endmodule : vec_unit

/* tb.f */
+incdir+dv
hdl/ara_lite_pkg.sv
hdl/acc_req_if.sv
hdl/acc_resp_if.sv
hdl/acc_dispatcher.sv
hdl/acc_insn_queue.sv
hdl/vec_unit.sv
hdl/ara_lite_system.sv
dv/tb_ara_lite.sv
